/* directory_bank.f */
logic/directory_pkg.sv
logic/request_table_if.sv
logic/request_issue.sv
logic/request_table.sv
logic/ack_return.sv
logic/disp_writeback.sv
logic/directory_bank.sv
testbench/tb_directory_bank.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_directory_bank -f directory_bank.f

out=$(./obj_dir/Vtb_directory_bank)
echo "$out"

# The run counts as passed only if the pass message was printed
echo "$out" | grep -q "Simulation finished: PASS"

/* testbench/tb_directory_bank.sv */
`timescale 1ns/1ps

module tb_directory_bank import directory_pkg::*; ();

  localparam int drid_bits = 2;
  localparam int num_ids = 1 << drid_bits;
  // Rough cycle budget of each test in test order
  localparam int test_cycles = 10 + 40 + 40 + 60 + 30 + 80;
  localparam int cycle_limit = 4 * test_cycles;

  typedef struct packed {
    logic [paddr_bits-1:0] paddr;
    req_cmd_e              cmd;
    logic [nid_bits-1:0]   nid;
    logic [l2id_bits-1:0]  l2id;
  } req_item_t;

  typedef struct packed {
    logic [nid_bits-1:0]  nid;
    logic [l2id_bits-1:0] l2id;
    ack_code_e            code;
    logic [line_bits-1:0] line;
  } snack_item_t;

  typedef struct packed {
    logic [paddr_bits-1:0] paddr;
    logic [line_bits-1:0]  line;
    logic [mask_bits-1:0]  mask;
  } wb_item_t;

  typedef struct packed {
    logic [nid_bits-1:0]  nid;
    logic [l2id_bits-1:0] l2id;
  } dack_item_t;

  logic clk = 1'b0;
  logic rst = 1'b1;

  logic l2todr_req_valid, l2todr_req_retry;
  logic [paddr_bits-1:0] l2todr_req_paddr;
  req_cmd_e l2todr_req_cmd;
  logic [nid_bits-1:0] l2todr_req_nid;
  logic [l2id_bits-1:0] l2todr_req_l2id;
  logic drtomem_req_valid, drtomem_req_retry;
  logic [paddr_bits-1:0] drtomem_req_paddr;
  req_cmd_e drtomem_req_cmd;
  logic [drid_bits-1:0] drtomem_req_drid;
  logic memtodr_ack_valid, memtodr_ack_retry;
  logic [drid_bits-1:0] memtodr_ack_drid;
  ack_code_e memtodr_ack_code;
  logic [line_bits-1:0] memtodr_ack_line;
  logic drtol2_snack_valid, drtol2_snack_retry;
  logic [nid_bits-1:0] drtol2_snack_nid;
  logic [l2id_bits-1:0] drtol2_snack_l2id;
  ack_code_e drtol2_snack_code;
  logic [line_bits-1:0] drtol2_snack_line;
  logic l2todr_disp_valid, l2todr_disp_retry;
  logic [paddr_bits-1:0] l2todr_disp_paddr;
  disp_cmd_e l2todr_disp_cmd;
  logic [nid_bits-1:0] l2todr_disp_nid;
  logic [l2id_bits-1:0] l2todr_disp_l2id;
  logic [line_bits-1:0] l2todr_disp_line;
  logic [mask_bits-1:0] l2todr_disp_mask;
  logic drtomem_wb_valid, drtomem_wb_retry;
  logic [paddr_bits-1:0] drtomem_wb_paddr;
  logic [line_bits-1:0] drtomem_wb_line;
  logic [mask_bits-1:0] drtomem_wb_mask;
  logic drtol2_dack_valid, drtol2_dack_retry;
  logic [nid_bits-1:0] drtol2_dack_nid;
  logic [l2id_bits-1:0] drtol2_dack_l2id;

  // Expected traffic per output channel in arrival order
  req_item_t   exp_req[$];
  snack_item_t exp_snack[$];
  wb_item_t    exp_wb[$];
  dack_item_t  exp_dack[$];

  // Memory model keeps the DRIDs sent to memory and not yet acked
  logic [drid_bits-1:0] mem_pending[$];
  logic                 drid_busy[num_ids];
  logic [nid_bits-1:0]  owner_nid[num_ids];
  logic [l2id_bits-1:0] owner_l2id[num_ids];
  logic [drid_bits-1:0] last_fwd_drid;
  logic [drid_bits-1:0] last_released;
  int fwd_count = 0;

  logic [15:0] lfsr = 16'd38;
  int errors = 0;
  int cycles = 0;
  int tests_ok = 0;
  int tests_bad = 0;
  int test_start_errors = 0;

  directory_bank #(.drid_bits(drid_bits)) directory_bank_inst (.*);

  always #50 clk = ~clk;

  // Fibonacci LFSR with taps at 16, 14, 13 and 11 that steps once per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r = {r[62:0], fb};
    end
    return r;
  endfunction

  function automatic void compare_value(input string name, input logic [63:0] exp_v,
                                        input logic [63:0] act_v);
    assert (exp_v === act_v) else begin
      $display("ERR %s expected %0h actual %0h", name, exp_v, act_v);
      errors++;
    end
  endfunction

  function automatic void report_problem(input string what);
    $display("Unexpected behavior: %s at cycle %0d", what, cycles);
    errors++;
  endfunction

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: run went past %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Scoreboard pops come before pushes so a same-edge load and drain keep their order
  always @(posedge clk) begin : monitor
    req_item_t   er;
    snack_item_t es;
    wb_item_t    ew;
    dack_item_t  ed;
    if (!rst) begin
      if (drtomem_req_valid && !drtomem_req_retry) begin
        assert (exp_req.size() > 0) else report_problem("memory request with none expected");
        if (exp_req.size() > 0) begin
          er = exp_req.pop_front();
          compare_value("drtomem_req_paddr", 64'(er.paddr), 64'(drtomem_req_paddr));
          compare_value("drtomem_req_cmd", 64'(er.cmd), 64'(drtomem_req_cmd));
          assert (!drid_busy[drtomem_req_drid]) else report_problem("DRID handed out twice");
          drid_busy[drtomem_req_drid] = 1'b1;
          owner_nid[drtomem_req_drid] = er.nid;
          owner_l2id[drtomem_req_drid] = er.l2id;
          mem_pending.push_back(drtomem_req_drid);
          last_fwd_drid = drtomem_req_drid;
          fwd_count++;
        end
      end
      if (drtol2_snack_valid && !drtol2_snack_retry) begin
        assert (exp_snack.size() > 0) else report_problem("snack with none expected");
        if (exp_snack.size() > 0) begin
          es = exp_snack.pop_front();
          compare_value("drtol2_snack_nid", 64'(es.nid), 64'(drtol2_snack_nid));
          compare_value("drtol2_snack_l2id", 64'(es.l2id), 64'(drtol2_snack_l2id));
          compare_value("drtol2_snack_code", 64'(es.code), 64'(drtol2_snack_code));
          compare_value("drtol2_snack_line", es.line, drtol2_snack_line);
        end
      end
      if (drtomem_wb_valid && !drtomem_wb_retry) begin
        assert (exp_wb.size() > 0) else report_problem("writeback with none expected");
        if (exp_wb.size() > 0) begin
          ew = exp_wb.pop_front();
          compare_value("drtomem_wb_paddr", 64'(ew.paddr), 64'(drtomem_wb_paddr));
          compare_value("drtomem_wb_line", ew.line, drtomem_wb_line);
          compare_value("drtomem_wb_mask", 64'(ew.mask), 64'(drtomem_wb_mask));
        end
      end
      if (drtol2_dack_valid && !drtol2_dack_retry) begin
        assert (exp_dack.size() > 0) else report_problem("dack with none expected");
        if (exp_dack.size() > 0) begin
          ed = exp_dack.pop_front();
          compare_value("drtol2_dack_nid", 64'(ed.nid), 64'(drtol2_dack_nid));
          compare_value("drtol2_dack_l2id", 64'(ed.l2id), 64'(drtol2_dack_l2id));
        end
      end
      // An accepted ack must come back to whoever was given its DRID
      if (memtodr_ack_valid && !memtodr_ack_retry) begin
        es.nid = owner_nid[memtodr_ack_drid];
        es.l2id = owner_l2id[memtodr_ack_drid];
        es.code = memtodr_ack_code;
        es.line = memtodr_ack_line;
        exp_snack.push_back(es);
        drid_busy[memtodr_ack_drid] = 1'b0;
        last_released = memtodr_ack_drid;
      end
      if (l2todr_disp_valid && !l2todr_disp_retry) begin
        ed.nid = l2todr_disp_nid;
        ed.l2id = l2todr_disp_l2id;
        exp_dack.push_back(ed);
        if (l2todr_disp_cmd != disp_none) begin
          ew.paddr = l2todr_disp_paddr;
          ew.line = l2todr_disp_line;
          ew.mask = l2todr_disp_mask;
          exp_wb.push_back(ew);
        end
      end
    end
  end

  // Stalled outputs must hold valid and payload until the retry drops
  logic req_held, snack_held, wb_held;
  logic [paddr_bits+drid_bits+1:0] req_saved;
  logic [line_bits+l2id_bits+nid_bits+1:0] snack_saved;
  logic [paddr_bits+line_bits+mask_bits-1:0] wb_saved;

  always @(posedge clk) begin
    if (rst) begin
      req_held = 1'b0;
      snack_held = 1'b0;
      wb_held = 1'b0;
    end else begin
      if (req_held) begin
        assert (drtomem_req_valid) else report_problem("stalled memory request dropped");
        compare_value("drtomem_req_paddr", 64'(req_saved[paddr_bits+drid_bits+1:drid_bits+2]),
                      64'(drtomem_req_paddr));
        compare_value("drtomem_req_cmd", 64'(req_saved[drid_bits+1:drid_bits]),
                      64'(drtomem_req_cmd));
        compare_value("drtomem_req_drid", 64'(req_saved[drid_bits-1:0]),
                      64'(drtomem_req_drid));
      end
      if (snack_held) begin
        assert (drtol2_snack_valid) else report_problem("stalled snack dropped");
        compare_value("drtol2_snack_nid",
                      64'(snack_saved[line_bits+l2id_bits+nid_bits+1:line_bits+l2id_bits+2]),
                      64'(drtol2_snack_nid));
        compare_value("drtol2_snack_l2id", 64'(snack_saved[line_bits+l2id_bits+1:line_bits+2]),
                      64'(drtol2_snack_l2id));
        compare_value("drtol2_snack_code", 64'(snack_saved[line_bits+1:line_bits]),
                      64'(drtol2_snack_code));
        compare_value("drtol2_snack_line", snack_saved[line_bits-1:0], drtol2_snack_line);
      end
      if (wb_held) begin
        assert (drtomem_wb_valid) else report_problem("stalled writeback dropped");
        compare_value("drtomem_wb_paddr",
                      64'(wb_saved[paddr_bits+line_bits+mask_bits-1:line_bits+mask_bits]),
                      64'(drtomem_wb_paddr));
        compare_value("drtomem_wb_line", wb_saved[line_bits+mask_bits-1:mask_bits],
                      drtomem_wb_line);
        compare_value("drtomem_wb_mask", 64'(wb_saved[mask_bits-1:0]), 64'(drtomem_wb_mask));
      end
      req_held = drtomem_req_valid && drtomem_req_retry;
      snack_held = drtol2_snack_valid && drtol2_snack_retry;
      wb_held = drtomem_wb_valid && drtomem_wb_retry;
      req_saved = {drtomem_req_paddr, drtomem_req_cmd, drtomem_req_drid};
      snack_saved = {drtol2_snack_nid, drtol2_snack_l2id, drtol2_snack_code, drtol2_snack_line};
      wb_saved = {drtomem_wb_paddr, drtomem_wb_line, drtomem_wb_mask};
    end
  end

  task automatic issue_req(input logic [nid_bits-1:0] nid, input logic [l2id_bits-1:0] l2id);
    req_item_t it;
    logic [63:0] rb;
    @(negedge clk);
    rb = rand_bits(1);
    it.paddr = paddr_bits'(rand_bits(paddr_bits));
    it.cmd = rb[0] ? req_read_excl : req_read_shared;
    it.nid = nid;
    it.l2id = l2id;
    l2todr_req_valid = 1'b1;
    l2todr_req_paddr = it.paddr;
    l2todr_req_cmd = it.cmd;
    l2todr_req_nid = nid;
    l2todr_req_l2id = l2id;
    do @(posedge clk); while (l2todr_req_retry);
    exp_req.push_back(it);
    @(negedge clk);
    l2todr_req_valid = 1'b0;
  endtask

  // Memory model acks one outstanding DRID chosen at random
  task automatic ack_one();
    int idx;
    logic [63:0] rb;
    @(negedge clk);
    while (mem_pending.size() == 0) @(negedge clk);
    rb = rand_bits(2);
    idx = int'(rb[1:0]) % mem_pending.size();
    memtodr_ack_drid = mem_pending[idx];
    mem_pending.delete(idx);
    rb = rand_bits(2);
    memtodr_ack_code = ack_code_e'(rb[1:0]);
    memtodr_ack_line = rand_bits(line_bits);
    memtodr_ack_valid = 1'b1;
    do @(posedge clk); while (memtodr_ack_retry);
    @(negedge clk);
    memtodr_ack_valid = 1'b0;
  endtask

  task automatic send_disp(input disp_cmd_e cmd, input logic [nid_bits-1:0] nid,
                           input logic [l2id_bits-1:0] l2id);
    @(negedge clk);
    l2todr_disp_valid = 1'b1;
    l2todr_disp_cmd = cmd;
    l2todr_disp_nid = nid;
    l2todr_disp_l2id = l2id;
    l2todr_disp_paddr = paddr_bits'(rand_bits(paddr_bits));
    l2todr_disp_line = rand_bits(line_bits);
    l2todr_disp_mask = mask_bits'(rand_bits(mask_bits));
    do @(posedge clk); while (l2todr_disp_retry);
    @(negedge clk);
    l2todr_disp_valid = 1'b0;
  endtask

  // Returns on a falling edge so the next stimulus can start right away
  task automatic wait_drain();
    while (exp_req.size() + exp_snack.size() + exp_wb.size() + exp_dack.size() > 0) begin
      @(posedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  task automatic end_test(input string name);
    if (errors == test_start_errors) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: %0d errors", name, errors - test_start_errors);
      tests_bad++;
    end
    test_start_errors = errors;
  endtask

  initial begin
    int held_fwd;
    {l2todr_req_valid, memtodr_ack_valid, l2todr_disp_valid} = '0;
    {drtomem_req_retry, drtol2_snack_retry, drtomem_wb_retry, drtol2_dack_retry} = '0;
    l2todr_req_paddr = '0;
    l2todr_req_cmd = req_read_shared;
    l2todr_req_nid = '0;
    l2todr_req_l2id = '0;
    memtodr_ack_drid = '0;
    memtodr_ack_code = ack_shared;
    memtodr_ack_line = '0;
    l2todr_disp_paddr = '0;
    l2todr_disp_cmd = disp_none;
    l2todr_disp_nid = '0;
    l2todr_disp_l2id = '0;
    l2todr_disp_line = '0;
    l2todr_disp_mask = '0;
    for (int i = 0; i < num_ids; i++) begin
      drid_busy[i] = 1'b0;
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;

    @(negedge clk);
    assert (!(drtomem_req_valid || drtol2_snack_valid || drtomem_wb_valid || drtol2_dack_valid))
      else report_problem("output valid high after reset");
    assert (!(l2todr_req_retry || memtodr_ack_retry || l2todr_disp_retry))
      else report_problem("input retry high after reset");
    end_test("reset_state");

    for (int i = 0; i < 4; i++) begin
      issue_req(nid_bits'(i + 3), l2id_bits'(i + 10));
    end
    wait_drain();
    end_test("request_forward");
    repeat (4) ack_one();
    wait_drain();
    end_test("ack_any_order");

    // Fill every DRID so that a fifth request has to wait for an ack
    for (int i = 0; i < 4; i++) begin
      issue_req(nid_bits'(i + 20), l2id_bits'(i + 40));
    end
    wait_drain();
    held_fwd = fwd_count;
    fork
      issue_req(5'd31, 6'd63);
      begin
        repeat (8) begin
          @(posedge clk);
          assert (l2todr_req_retry) else report_problem("retry low with no DRID free");
        end
        assert (fwd_count == held_fwd) else report_problem("fifth request forwarded");
        ack_one();
      end
    join
    wait_drain();
    compare_value("drtomem_req_drid", 64'(last_released), 64'(last_fwd_drid));
    repeat (4) ack_one();
    wait_drain();
    end_test("drid_exhaust");

    send_disp(disp_none, 5'd1, 6'd2);
    send_disp(disp_clean, 5'd3, 6'd4);
    send_disp(disp_dirty, 5'd5, 6'd6);
    wait_drain();
    end_test("displacement");

    drtomem_req_retry = 1'b1;
    fork
      begin
        issue_req(5'd7, 6'd8);
        issue_req(5'd9, 6'd10);
      end
      begin
        repeat (6) @(negedge clk);
        drtomem_req_retry = 1'b0;
      end
    join
    wait_drain();
    drtol2_snack_retry = 1'b1;
    fork
      begin
        ack_one();
        ack_one();
      end
      begin
        repeat (6) @(negedge clk);
        drtol2_snack_retry = 1'b0;
      end
    join
    drtomem_wb_retry = 1'b1;
    fork
      begin
        send_disp(disp_dirty, 5'd11, 6'd12);
        send_disp(disp_clean, 5'd13, 6'd14);
      end
      begin
        repeat (6) @(negedge clk);
        drtomem_wb_retry = 1'b0;
      end
    join
    wait_drain();
    end_test("backpressure");

    $display("tests passed %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* logic/directory_bank.sv */
`timescale 1ns/1ps

module directory_bank import directory_pkg::*; #(
  parameter int drid_bits = 4
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  l2todr_req_valid,
  output logic                  l2todr_req_retry,
  input  logic [paddr_bits-1:0] l2todr_req_paddr,
  input  req_cmd_e              l2todr_req_cmd,
  input  logic [nid_bits-1:0]   l2todr_req_nid,
  input  logic [l2id_bits-1:0]  l2todr_req_l2id,

  output logic                  drtomem_req_valid,
  input  logic                  drtomem_req_retry,
  output logic [paddr_bits-1:0] drtomem_req_paddr,
  output req_cmd_e              drtomem_req_cmd,
  output logic [drid_bits-1:0]  drtomem_req_drid,

  input  logic                  memtodr_ack_valid,
  output logic                  memtodr_ack_retry,
  input  logic [drid_bits-1:0]  memtodr_ack_drid,
  input  ack_code_e             memtodr_ack_code,
  input  logic [line_bits-1:0]  memtodr_ack_line,

  output logic                  drtol2_snack_valid,
  input  logic                  drtol2_snack_retry,
  output logic [nid_bits-1:0]   drtol2_snack_nid,
  output logic [l2id_bits-1:0]  drtol2_snack_l2id,
  output ack_code_e             drtol2_snack_code,
  output logic [line_bits-1:0]  drtol2_snack_line,

  input  logic                  l2todr_disp_valid,
  output logic                  l2todr_disp_retry,
  input  logic [paddr_bits-1:0] l2todr_disp_paddr,
  input  disp_cmd_e             l2todr_disp_cmd,
  input  logic [nid_bits-1:0]   l2todr_disp_nid,
  input  logic [l2id_bits-1:0]  l2todr_disp_l2id,
  input  logic [line_bits-1:0]  l2todr_disp_line,
  input  logic [mask_bits-1:0]  l2todr_disp_mask,

  output logic                  drtomem_wb_valid,
  input  logic                  drtomem_wb_retry,
  output logic [paddr_bits-1:0] drtomem_wb_paddr,
  output logic [line_bits-1:0]  drtomem_wb_line,
  output logic [mask_bits-1:0]  drtomem_wb_mask,

  output logic                  drtol2_dack_valid,
  input  logic                  drtol2_dack_retry,
  output logic [nid_bits-1:0]   drtol2_dack_nid,
  output logic [l2id_bits-1:0]  drtol2_dack_l2id
);

  // Lookup path from the ack side into the table
  logic [drid_bits-1:0] lookup_drid;
  logic [nid_bits-1:0]  lookup_nid;
  logic [l2id_bits-1:0] lookup_l2id;

  // DRID release from the ack side back to the free list
  logic                 release_valid;
  logic [drid_bits-1:0] release_drid;

  request_table_if #(.drid_bits(drid_bits)) table_wr ();

  request_issue #(.drid_bits(drid_bits)) request_issue_inst (
    .clk               (clk),
    .rst               (rst),
    .l2todr_req_valid  (l2todr_req_valid),
    .l2todr_req_retry  (l2todr_req_retry),
    .l2todr_req_paddr  (l2todr_req_paddr),
    .l2todr_req_cmd    (l2todr_req_cmd),
    .l2todr_req_nid    (l2todr_req_nid),
    .l2todr_req_l2id   (l2todr_req_l2id),
    .drtomem_req_valid (drtomem_req_valid),
    .drtomem_req_retry (drtomem_req_retry),
    .drtomem_req_paddr (drtomem_req_paddr),
    .drtomem_req_cmd   (drtomem_req_cmd),
    .drtomem_req_drid  (drtomem_req_drid),
    .table_wr          (table_wr.producer),
    .release_valid     (release_valid),
    .release_drid      (release_drid)
  );

  request_table #(.drid_bits(drid_bits)) request_table_inst (
    .clk         (clk),
    .table_wr    (table_wr.tbl),
    .lookup_drid (lookup_drid),
    .lookup_nid  (lookup_nid),
    .lookup_l2id (lookup_l2id)
  );

  ack_return #(.drid_bits(drid_bits)) ack_return_inst (
    .clk                (clk),
    .rst                (rst),
    .memtodr_ack_valid  (memtodr_ack_valid),
    .memtodr_ack_retry  (memtodr_ack_retry),
    .memtodr_ack_drid   (memtodr_ack_drid),
    .memtodr_ack_code   (memtodr_ack_code),
    .memtodr_ack_line   (memtodr_ack_line),
    .drtol2_snack_valid (drtol2_snack_valid),
    .drtol2_snack_retry (drtol2_snack_retry),
    .drtol2_snack_nid   (drtol2_snack_nid),
    .drtol2_snack_l2id  (drtol2_snack_l2id),
    .drtol2_snack_code  (drtol2_snack_code),
    .drtol2_snack_line  (drtol2_snack_line),
    .lookup_drid        (lookup_drid),
    .lookup_nid         (lookup_nid),
    .lookup_l2id        (lookup_l2id),
    .release_valid      (release_valid),
    .release_drid       (release_drid)
  );

  // Displacements bypass the DRID machinery entirely
  disp_writeback disp_writeback_inst (
    .clk               (clk),
    .rst               (rst),
    .l2todr_disp_valid (l2todr_disp_valid),
    .l2todr_disp_retry (l2todr_disp_retry),
    .l2todr_disp_paddr (l2todr_disp_paddr),
    .l2todr_disp_cmd   (l2todr_disp_cmd),
    .l2todr_disp_nid   (l2todr_disp_nid),
    .l2todr_disp_l2id  (l2todr_disp_l2id),
    .l2todr_disp_line  (l2todr_disp_line),
    .l2todr_disp_mask  (l2todr_disp_mask),
    .drtomem_wb_valid  (drtomem_wb_valid),
    .drtomem_wb_retry  (drtomem_wb_retry),
    .drtomem_wb_paddr  (drtomem_wb_paddr),
    .drtomem_wb_line   (drtomem_wb_line),
    .drtomem_wb_mask   (drtomem_wb_mask),
    .drtol2_dack_valid (drtol2_dack_valid),
    .drtol2_dack_retry (drtol2_dack_retry),
    .drtol2_dack_nid   (drtol2_dack_nid),
    .drtol2_dack_l2id  (drtol2_dack_l2id)
  );

endmodule

/* logic/disp_writeback.sv */
`timescale 1ns/1ps

module disp_writeback import directory_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  l2todr_disp_valid,
  output logic                  l2todr_disp_retry,
  input  logic [paddr_bits-1:0] l2todr_disp_paddr,
  input  disp_cmd_e             l2todr_disp_cmd,
  input  logic [nid_bits-1:0]   l2todr_disp_nid,
  input  logic [l2id_bits-1:0]  l2todr_disp_l2id,
  input  logic [line_bits-1:0]  l2todr_disp_line,
  input  logic [mask_bits-1:0]  l2todr_disp_mask,

  output logic                  drtomem_wb_valid,
  input  logic                  drtomem_wb_retry,
  output logic [paddr_bits-1:0] drtomem_wb_paddr,
  output logic [line_bits-1:0]  drtomem_wb_line,
  output logic [mask_bits-1:0]  drtomem_wb_mask,

  output logic                  drtol2_dack_valid,
  input  logic                  drtol2_dack_retry,
  output logic [nid_bits-1:0]   drtol2_dack_nid,
  output logic [l2id_bits-1:0]  drtol2_dack_l2id
);

  logic needs_wb;
  logic wb_stalled;
  logic dack_stalled;
  logic accept;
  logic wb_load;

  // Clean and dirty lines both go back to memory in passthrough mode
  assign needs_wb = l2todr_disp_cmd != disp_none;

  assign wb_stalled = drtomem_wb_valid && drtomem_wb_retry;
  assign dack_stalled = drtol2_dack_valid && drtol2_dack_retry;

  // A stalled writeback only blocks displacements that would need it
  assign l2todr_disp_retry = dack_stalled || (needs_wb && wb_stalled);
  assign accept = l2todr_disp_valid && !l2todr_disp_retry;
  assign wb_load = accept && needs_wb;

  always_ff @(posedge clk) begin
    if (rst) begin
      drtol2_dack_valid <= 1'b0;
      drtomem_wb_valid <= 1'b0;
    end else begin
      if (accept) begin
        drtol2_dack_valid <= 1'b1;
      end else if (!drtol2_dack_retry) begin
        drtol2_dack_valid <= 1'b0;
      end
      if (wb_load) begin
        drtomem_wb_valid <= 1'b1;
      end else if (!drtomem_wb_retry) begin
        drtomem_wb_valid <= 1'b0;
      end
    end
  end

  // Both payloads come from the same displacement on the same edge
  always_ff @(posedge clk) begin
    if (accept) begin
      drtol2_dack_nid <= l2todr_disp_nid;
      drtol2_dack_l2id <= l2todr_disp_l2id;
    end
    if (wb_load) begin
      drtomem_wb_paddr <= l2todr_disp_paddr;
      drtomem_wb_line <= l2todr_disp_line;
      drtomem_wb_mask <= l2todr_disp_mask;
    end
  end

endmodule

/* logic/ack_return.sv */
`timescale 1ns/1ps

module ack_return import directory_pkg::*; #(
  parameter int drid_bits = 4
) (
  input  logic                 clk,
  input  logic                 rst,

  input  logic                 memtodr_ack_valid,
  output logic                 memtodr_ack_retry,
  input  logic [drid_bits-1:0] memtodr_ack_drid,
  input  ack_code_e            memtodr_ack_code,
  input  logic [line_bits-1:0] memtodr_ack_line,

  output logic                 drtol2_snack_valid,
  input  logic                 drtol2_snack_retry,
  output logic [nid_bits-1:0]  drtol2_snack_nid,
  output logic [l2id_bits-1:0] drtol2_snack_l2id,
  output ack_code_e            drtol2_snack_code,
  output logic [line_bits-1:0] drtol2_snack_line,

  output logic [drid_bits-1:0] lookup_drid,
  input  logic [nid_bits-1:0]  lookup_nid,
  input  logic [l2id_bits-1:0] lookup_l2id,

  output logic                 release_valid,
  output logic [drid_bits-1:0] release_drid
);

  logic accept;

  // The ack's DRID only indexes the table and is dropped after that
  assign lookup_drid = memtodr_ack_drid;

  assign memtodr_ack_retry = drtol2_snack_valid && drtol2_snack_retry;
  assign accept = memtodr_ack_valid && !memtodr_ack_retry;

  // The DRID goes back to the free list as soon as its ack is taken
  assign release_valid = accept;
  assign release_drid = memtodr_ack_drid;

  always_ff @(posedge clk) begin
    if (rst) begin
      drtol2_snack_valid <= 1'b0;
    end else if (accept) begin
      drtol2_snack_valid <= 1'b1;
    end else if (!drtol2_snack_retry) begin
      drtol2_snack_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      drtol2_snack_nid <= lookup_nid;
      drtol2_snack_l2id <= lookup_l2id;
      drtol2_snack_code <= memtodr_ack_code;
      drtol2_snack_line <= memtodr_ack_line;
    end
  end

endmodule

/* logic/request_table.sv */
`timescale 1ns/1ps

module request_table import directory_pkg::*; #(
  parameter int drid_bits = 4
) (
  input  logic                 clk,

  request_table_if.tbl         table_wr,

  input  logic [drid_bits-1:0] lookup_drid,
  output logic [nid_bits-1:0]  lookup_nid,
  output logic [l2id_bits-1:0] lookup_l2id
);

  localparam int num_ids = 1 << drid_bits;

  // Who asked for each outstanding DRID
  logic [nid_bits-1:0]  nid_mem  [num_ids];
  logic [l2id_bits-1:0] l2id_mem [num_ids];

  // Single write port owned by the issuer
  always_ff @(posedge clk) begin
    if (table_wr.valid) begin
      nid_mem[table_wr.drid] <= table_wr.nid;
      l2id_mem[table_wr.drid] <= table_wr.l2id;
    end
  end

  // Combinational read so the ack can be answered in the cycle it arrives
  assign lookup_nid = nid_mem[lookup_drid];
  assign lookup_l2id = l2id_mem[lookup_drid];

endmodule

/* logic/request_issue.sv */
`timescale 1ns/1ps

module request_issue import directory_pkg::*; #(
  parameter int drid_bits = 4
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  l2todr_req_valid,
  output logic                  l2todr_req_retry,
  input  logic [paddr_bits-1:0] l2todr_req_paddr,
  input  req_cmd_e              l2todr_req_cmd,
  input  logic [nid_bits-1:0]   l2todr_req_nid,
  input  logic [l2id_bits-1:0]  l2todr_req_l2id,

  output logic                  drtomem_req_valid,
  input  logic                  drtomem_req_retry,
  output logic [paddr_bits-1:0] drtomem_req_paddr,
  output req_cmd_e              drtomem_req_cmd,
  output logic [drid_bits-1:0]  drtomem_req_drid,

  request_table_if.producer     table_wr,

  input  logic                  release_valid,
  input  logic [drid_bits-1:0]  release_drid
);

  localparam int num_ids = 1 << drid_bits;

  // One bit per DRID that is set while the ID is not held by an outstanding request
  logic [num_ids-1:0]   free_q;
  logic [num_ids-1:0]   free_next;
  logic [drid_bits-1:0] pick_drid;
  logic                 any_free;
  logic                 out_can_load;
  logic                 accept;

  // Lowest free DRID wins, so scan from the top and let lower hits overwrite
  always_comb begin
    pick_drid = '0;
    for (int i = num_ids - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        pick_drid = drid_bits'(i);
      end
    end
  end

  assign any_free = |free_q;

  // The memory request register can take a new entry when empty or draining
  assign out_can_load = !drtomem_req_valid || !drtomem_req_retry;

  assign l2todr_req_retry = !out_can_load || !any_free;
  assign accept = l2todr_req_valid && !l2todr_req_retry;

  // The picked ID is always free and a released ID never is, so the two never collide
  always_comb begin
    free_next = free_q;
    if (accept) begin
      free_next[pick_drid] = 1'b0;
    end
    if (release_valid) begin
      free_next[release_drid] = 1'b1;
    end
  end

  // Requester IDs go into the table on the same edge the request is taken
  assign table_wr.valid = accept;
  assign table_wr.drid = pick_drid;
  assign table_wr.nid = l2todr_req_nid;
  assign table_wr.l2id = l2todr_req_l2id;

  always_ff @(posedge clk) begin
    if (rst) begin
      free_q <= '1;
      drtomem_req_valid <= 1'b0;
    end else begin
      free_q <= free_next;
      if (accept) begin
        drtomem_req_valid <= 1'b1;
      end else if (!drtomem_req_retry) begin
        drtomem_req_valid <= 1'b0;
      end
    end
  end

  // Payload only changes on a load, so a stalled request holds steady
  always_ff @(posedge clk) begin
    if (accept) begin
      drtomem_req_paddr <= l2todr_req_paddr;
      drtomem_req_cmd <= l2todr_req_cmd;
      drtomem_req_drid <= pick_drid;
    end
  end

endmodule

/* logic/request_table_if.sv */
`timescale 1ns/1ps

// Write port into the DRID table that carries one entry per accepted L2 request
interface request_table_if import directory_pkg::*; #(
  parameter int drid_bits = 4
);

  logic                 valid;
  logic [drid_bits-1:0] drid;
  logic [nid_bits-1:0]  nid;
  logic [l2id_bits-1:0] l2id;

  // The issuer drives the write and the table always takes it
  modport producer (output valid, drid, nid, l2id);

  modport tbl (input valid, drid, nid, l2id);

endinterface

/* logic/directory_pkg.sv */
package directory_pkg;

  // Physical line address carried on requests, displacements and writebacks
  parameter int paddr_bits = 40;

  // Data line width standing in for the full 512-bit line
  parameter int line_bits = 64;

  // One mask bit per byte of the line
  parameter int mask_bits = line_bits / 8;

  // Requester identification returned on every ack to the L2
  parameter int nid_bits = 5;
  parameter int l2id_bits = 6;

  // L2 read commands that are forwarded to memory as they arrive
  typedef enum logic [1:0] {
    req_read_shared = 2'b00,
    req_read_excl   = 2'b01
  } req_cmd_e;

  // Displacement kinds where only disp_none goes without a writeback
  typedef enum logic [1:0] {
    disp_none  = 2'b00,
    disp_clean = 2'b01,
    disp_dirty = 2'b10
  } disp_cmd_e;

  // Memory ack kinds that are handed to the L2 unchanged on the snack
  typedef enum logic [1:0] {
    ack_shared    = 2'b00,
    ack_exclusive = 2'b01,
    ack_modified  = 2'b10,
    ack_nack      = 2'b11
  } ack_code_e;

endpackage
